// File: test/openfire_rf_trace.txt
# a_addr b_addr d_addr sel we_alu we_rf enable result pc dmem chk exp_a exp_b exp_d (all hex)
# chk 0 no check, 1 check before next falling edge, 2 check before the write edge
00 00 00 5 0 0 0 00000000 000 00000000 1 00000000 00000000 00000000
00 00 00 3 1 0 1 deadbeef 000 00000000 1 00000000 00000000 00000000
00 00 00 3 0 1 1 12345678 000 00000000 1 00000000 00000000 00000000
00 00 01 3 1 0 1 11111111 000 00000000 1 00000000 00000000 11111111
01 01 01 5 0 0 0 00000000 000 00000000 1 11111111 11111111 11111111
01 01 01 3 1 0 1 22222222 000 00000000 2 11111111 11111111 11111111
01 01 01 5 0 0 0 00000000 000 00000000 1 22222222 22222222 22222222
00 00 02 3 0 1 1 a5a5a5a5 000 00000000 1 00000000 00000000 a5a5a5a5
01 02 02 5 0 0 0 00000000 000 00000000 1 22222222 a5a5a5a5 a5a5a5a5
02 01 01 3 1 1 1 33333333 000 00000000 2 a5a5a5a5 22222222 22222222
02 01 01 5 0 0 0 00000000 000 00000000 1 a5a5a5a5 33333333 33333333
00 00 03 0 0 1 1 00000000 000 89abcdef 1 00000000 00000000 00000089
03 03 04 1 0 1 1 00000000 000 89abcdef 1 00000089 00000089 000089ab
04 03 05 2 0 1 1 00000000 000 89abcdef 1 000089ab 00000089 89abcdef
05 04 05 5 0 0 0 00000000 000 89abcdef 1 89abcdef 000089ab 89abcdef
00 00 06 0 1 0 1 ffffffff 000 7f00aa55 1 00000000 00000000 0000007f
06 06 07 1 0 1 1 ffffffff 000 fedcba98 1 0000007f 0000007f 0000fedc
07 05 08 2 0 1 1 00000000 000 0badf00d 1 0000fedc 89abcdef 0badf00d
00 00 09 4 1 0 1 ffffffff ffc 00000000 1 00000000 00000000 00000ffc
09 09 0a 4 1 0 1 00000000 123 ffffffff 1 00000ffc 00000ffc 00000123
0a 09 0a 4 0 1 1 00000000 800 00000000 1 00000800 00000ffc 00000800
01 02 01 3 1 0 0 deadbeef 000 00000000 1 33333333 a5a5a5a5 33333333
01 02 02 3 0 0 1 deadbeef 000 00000000 1 33333333 a5a5a5a5 a5a5a5a5
03 04 03 2 0 1 0 00000000 000 cafef00d 1 00000089 000089ab 00000089
05 05 05 0 1 1 0 00000000 000 cafef00d 1 89abcdef 89abcdef 89abcdef
00 00 0b 3 1 0 1 0000abcd 000 00000000 1 00000000 00000000 0000abcd
0b 08 0c 3 1 0 1 12340000 000 00000000 1 0000abcd 0badf00d 12340000
0c 0b 1f 3 1 0 1 ffffffff 000 00000000 1 12340000 0000abcd ffffffff
1f 0c 1f 5 1 0 1 aaaaaaaa 000 00000000 2 ffffffff 12340000 ffffffff
1f 0c 1f 5 0 0 0 00000000 000 00000000 1 00000000 12340000 00000000
08 1f 0b 5 0 1 1 00000000 000 ffffffff 1 0badf00d 00000000 00000000
0b 08 08 5 0 0 0 00000000 000 00000000 1 00000000 0badf00d 0badf00d
00 00 0d 3 1 0 1 00000001 000 00000000 1 00000000 00000000 00000001
00 00 0e 3 1 0 1 00000002 000 00000000 1 00000000 00000000 00000002
00 00 0f 3 1 0 1 00000004 000 00000000 1 00000000 00000000 00000004
00 00 10 3 1 0 1 80000000 000 00000000 1 00000000 00000000 80000000
00 00 11 3 1 0 1 40000000 000 00000000 1 00000000 00000000 40000000
0d 0e 10 5 0 0 0 00000000 000 00000000 1 00000001 00000002 80000000
0f 11 0d 5 0 0 0 00000000 000 00000000 1 00000004 40000000 00000001
10 0f 11 5 0 0 0 00000000 000 00000000 1 80000000 00000004 40000000
0d 0e 0d 2 0 1 1 00000000 000 5a5a5a5a 2 00000001 00000002 00000001
0d 0e 0d 5 0 0 0 00000000 000 00000000 1 5a5a5a5a 00000002 5a5a5a5a
00 0d 00 2 0 1 1 00000000 000 ffffffff 1 00000000 5a5a5a5a 00000000
00 00 00 4 1 1 1 ffffffff fff ffffffff 1 00000000 00000000 00000000
00 00 12 1 0 1 1 00000000 000 0000ffff 1 00000000 00000000 00000000
00 00 13 0 0 1 1 00000000 000 00ffffff 1 00000000 00000000 00000000
12 13 14 1 0 1 1 00000000 000 ffff0000 1 00000000 00000000 0000ffff
14 12 14 5 0 0 0 00000000 000 00000000 1 0000ffff 00000000 0000ffff
00 00 15 4 0 1 1 00000000 000 00000000 1 00000000 00000000 00000000
15 14 15 4 1 0 1 00000000 001 00000000 1 00000001 0000ffff 00000001
01 02 03 3 1 1 0 ffffffff 000 00000000 1 33333333 a5a5a5a5 00000089
04 05 06 5 0 0 0 00000000 000 00000000 1 000089ab 89abcdef 0000007f
07 08 09 5 0 0 0 00000000 000 00000000 1 0000fedc 0badf00d 00000ffc
0a 0b 0c 5 0 0 0 00000000 000 00000000 1 00000800 00000000 12340000
1f 10 11 5 0 0 0 00000000 000 00000000 1 00000000 80000000 40000000
00 00 00 5 0 0 0 00000000 000 00000000 0 00000000 00000000 00000000

// File: build.f
src/openfire_pkg.sv
src/openfire_rf_sram.sv
src/openfire_regfile.sv
src/openfire_rf_top.sv
test/openfire_rf_checker.sv
test/openfire_rf_tb.sv

// File: test/openfire_rf_tb.sv
/*
	Register file testbench
	Trace-driven stimulus on falling edges, read port checks,
	watchdog sized from the trace length
*/
`timescale 1ns/1ns

module openfire_rf_tb;

	localparam int    A_SPACE      = 10;		// Same as the top default
	localparam int    CLK_PERIOD   = 20;
	localparam int    RESET_CYCLES = 10;
	localparam int    SLACK_CYCLES = 20;		// Watchdog margin
	localparam int    TRACE_FIELDS = 14;
	localparam string TRACE_FILE   = "test/openfire_rf_trace.txt";

	// DUT inputs
	logic                             clock;
	logic                             arst_n;
	logic [openfire_pkg::REG_AW-1:0] reg_a_addr;
	logic [openfire_pkg::REG_AW-1:0] reg_b_addr;
	logic [openfire_pkg::REG_AW-1:0] reg_d_addr;
	openfire_pkg::rf_sel_e            regfile_input_sel;
	logic                             we_alu_branch;
	logic                             we_regfile;
	logic                             enable;
	logic [openfire_pkg::DATA_W-1:0] result;
	logic [A_SPACE+1:0]               pc_regfile;
	logic [openfire_pkg::DATA_W-1:0] dmem_data;

	// DUT outputs
	logic [openfire_pkg::DATA_W-1:0] reg_a;
	logic [openfire_pkg::DATA_W-1:0] reg_b;
	logic [openfire_pkg::DATA_W-1:0] reg_d;

	string trace_lines [$];		// Data lines only, comments dropped
	int    trace_len;
	logic  trace_loaded;		// Starts the watchdog

	openfire_rf_top #(
		.A_SPACE (A_SPACE)
	) dut_i (
		.clock             (clock),
		.arst_n            (arst_n),
		.reg_a_addr        (reg_a_addr),
		.reg_b_addr        (reg_b_addr),
		.reg_d_addr        (reg_d_addr),
		.regfile_input_sel (regfile_input_sel),
		.we_alu_branch     (we_alu_branch),
		.we_regfile        (we_regfile),
		.enable            (enable),
		.result            (result),
		.pc_regfile        (pc_regfile),
		.dmem_data         (dmem_data),
		.reg_a             (reg_a),
		.reg_b             (reg_b),
		.reg_d             (reg_d)
	);

	// Assertions ride on the inner file, where write_en lives
	bind openfire_regfile openfire_rf_checker rf_checker_i (
		.clock             (clock),
		.arst_n            (arst_n),
		.write_en          (write_en),
		.regfile_input_sel (regfile_input_sel),
		.reg_a_addr        (reg_a_addr),
		.reg_d_addr        (reg_d_addr),
		.reg_a             (reg_a),
		.reg_d             (reg_d)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// Single point of comparison
	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("Error at %0t ns: %s read %h, expected %h", $time, what, got, expected);
			$display("Some tests failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// Pull every data line into memory, so the run length is known up front
	task automatic load_trace();
		int    fd;
		string line;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0)
		begin
			$display("Could not open the trace file %s", TRACE_FILE);
			$display("Some tests failed");
			$fatal(1, "no stimulus");
		end
		while (!$feof(fd))
		begin
			line = "";
			if ($fgets(line, fd) != 0)
			begin
				// Skip comments and blank lines
				if (line.len() > 1 && line[0] != "#" && line[0] != "\n" && line[0] != "\r")
					trace_lines.push_back(line);
			end
		end
		$fclose(fd);
		trace_len = trace_lines.size();
		if (trace_len == 0)
		begin
			$display("The trace file holds no stimulus lines");
			$display("Some tests failed");
			$fatal(1, "empty trace");
		end
	endtask

	// Parse one entry, drive its inputs, hand back the check request
	task automatic apply_line(input int idx, output int chk, output logic [31:0] exp_a,
		output logic [31:0] exp_b, output logic [31:0] exp_d);
		logic [31:0] a_adr, b_adr, d_adr, sel, w_alu, w_rf, en;
		logic [31:0] res, pc, dmem, flag;
		int          n;
		n = $sscanf(trace_lines[idx], "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
			a_adr, b_adr, d_adr, sel, w_alu, w_rf, en, res, pc, dmem,
			flag, exp_a, exp_b, exp_d);
		if (n != TRACE_FIELDS)
		begin
			$display("Trace entry %0d is malformed, found %0d fields", idx, n);
			$display("Some tests failed");
			$fatal(1, "bad trace line");
		end
		reg_a_addr        = a_adr[openfire_pkg::REG_AW-1:0];
		reg_b_addr        = b_adr[openfire_pkg::REG_AW-1:0];
		reg_d_addr        = d_adr[openfire_pkg::REG_AW-1:0];
		regfile_input_sel = openfire_pkg::rf_sel_e'(sel[3:0]);
		we_alu_branch     = w_alu[0];
		we_regfile        = w_rf[0];
		enable            = en[0];
		result            = res;
		pc_regfile        = pc[A_SPACE+1:0];		// Upper trace bits unused
		dmem_data         = dmem;
		chk               = int'(flag);
	endtask

	task automatic compare_reads(input int idx, input logic [31:0] exp_a,
		input logic [31:0] exp_b, input logic [31:0] exp_d);
		check_value($sformatf("entry %0d reg_a", idx), reg_a, exp_a);
		check_value($sformatf("entry %0d reg_b", idx), reg_b, exp_b);
		check_value($sformatf("entry %0d reg_d", idx), reg_d, exp_d);
	endtask

	// Stimulus and checking
	initial
	begin
		int          chk;
		logic [31:0] exp_a;
		logic [31:0] exp_b;
		logic [31:0] exp_d;
		clock             = 1'b0;
		arst_n            = 1'b0;
		reg_a_addr        = '0;
		reg_b_addr        = '0;
		reg_d_addr        = '0;		// Reset zero load lands on r0
		regfile_input_sel = openfire_pkg::rf_zero;
		we_alu_branch     = 1'b0;
		we_regfile        = 1'b0;
		enable            = 1'b0;
		result            = '0;
		pc_regfile        = '0;
		dmem_data         = '0;
		trace_loaded      = 1'b0;
		load_trace();
		trace_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
		foreach (trace_lines[i])
		begin
			apply_line(i, chk, exp_a, exp_b, exp_d);
			if (chk == 2)
			begin
				#(CLK_PERIOD / 2 - 2);		// Just ahead of the write edge
				compare_reads(i, exp_a, exp_b, exp_d);
			end
			else if (chk == 1)
			begin
				#(CLK_PERIOD - 2);		// Just ahead of the next falling edge
				compare_reads(i, exp_a, exp_b, exp_d);
			end
			@(negedge clock);
		end
		$display("All tests passed");
		$finish;
	end

	// Bound checker failures end the run
	always @(dut_i.u_regfile.rf_checker_i.assert_fails)
	begin
		if (dut_i.u_regfile.rf_checker_i.assert_fails != 0)
		begin
			$display("A register file assertion failed at %0t ns", $time);
			$display("Some tests failed");
			$fatal(1, "assertion failure");
		end
	end

	// Watchdog
	initial
	begin
		wait (trace_loaded === 1'b1);
		#((trace_len + SLACK_CYCLES) * CLK_PERIOD);
		$display("Timeout, the trace did not finish within %0d cycles",
			trace_len + SLACK_CYCLES);
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: test/openfire_rf_checker.sv
/*
	Register file assertions
	Legal write-source select on every write, r0 reads zero on port A,
	reset zero load seen on the D port
*/
`timescale 1ns/1ns

module openfire_rf_checker (
	input  logic                             clock,
	input  logic                             arst_n,
	input  logic                             write_en,		// Internal bank write enable
	input  openfire_pkg::rf_sel_e            regfile_input_sel,
	input  logic [openfire_pkg::REG_AW-1:0] reg_a_addr,
	input  logic [openfire_pkg::REG_AW-1:0] reg_d_addr,
	input  logic [openfire_pkg::DATA_W-1:0] reg_a,
	input  logic [openfire_pkg::DATA_W-1:0] reg_d
);

	int assert_fails = 0;		// Failed assertion count

	// Only the six defined codes may reach a bank
	sel_legal_a : assert property (
		@(posedge clock) write_en |-> (regfile_input_sel inside {
			openfire_pkg::rf_dmem_byte, openfire_pkg::rf_dmem_halfword,
			openfire_pkg::rf_dmem_wholeword, openfire_pkg::rf_alu_result,
			openfire_pkg::rf_pc, openfire_pkg::rf_zero})
	) else
	begin
		$error("write with illegal select code %0d", regfile_input_sel);
		assert_fails++;
	end

	// r0 hardwired to zero once out of reset
	r0_zero_a : assert property (
		@(posedge clock) disable iff (!arst_n)
		(reg_a_addr == '0) |-> (reg_a == '0)
	) else
	begin
		$error("r0 read nonzero value %h on port A", reg_a);
		assert_fails++;
	end

	// Reset edge loads zero into regD, read back one edge later
	reset_write_a : assert property (
		@(posedge clock) (!arst_n ##1 $stable(reg_d_addr)) |-> (reg_d == '0)
	) else
	begin
		$error("reset zero load missing, regD reads %h", reg_d);
		assert_fails++;
	end

endmodule

// File: src/openfire_rf_top.sv
/*
	Register file top level
	Sets the instruction address space and wires the file to the ports
*/
`timescale 1ns/1ns

module openfire_rf_top #(
	parameter int A_SPACE = 10		// 1K words of instruction space
) (
	input  logic                             clock,
	input  logic                             arst_n,
	input  logic [openfire_pkg::REG_AW-1:0] reg_a_addr,
	input  logic [openfire_pkg::REG_AW-1:0] reg_b_addr,
	input  logic [openfire_pkg::REG_AW-1:0] reg_d_addr,	// Write target, store source
	input  openfire_pkg::rf_sel_e            regfile_input_sel,
	input  logic                             we_alu_branch,
	input  logic                             we_regfile,
	input  logic                             enable,
	input  logic [openfire_pkg::DATA_W-1:0] result,
	input  logic [A_SPACE+1:0]               pc_regfile,
	input  logic [openfire_pkg::DATA_W-1:0] dmem_data,
	output logic [openfire_pkg::DATA_W-1:0] reg_a,		// Operand A
	output logic [openfire_pkg::DATA_W-1:0] reg_b,		// Operand B
	output logic [openfire_pkg::DATA_W-1:0] reg_d			// Store data
);

	// Straight connection, no added latency
	openfire_regfile #(
		.A_SPACE (A_SPACE)
	) u_regfile (
		.clock             (clock),
		.arst_n            (arst_n),
		.reg_a_addr        (reg_a_addr),
		.reg_b_addr        (reg_b_addr),
		.reg_d_addr        (reg_d_addr),
		.regfile_input_sel (regfile_input_sel),
		.we_alu_branch     (we_alu_branch),
		.we_regfile        (we_regfile),
		.enable            (enable),
		.result            (result),
		.pc_regfile        (pc_regfile),
		.dmem_data         (dmem_data),
		.reg_a             (reg_a),
		.reg_b             (reg_b),
		.reg_d             (reg_d)
	);

endmodule

// File: src/openfire_regfile.sv
/*
	Three-port register file
	Write-source mux, write enable with r0 protection and reset zero load
	Two dual-port banks with tied write ports
*/
`timescale 1ns/1ns

module openfire_regfile #(
	parameter int A_SPACE = 10		// Instruction space in words
) (
	input  logic                             clock,
	input  logic                             arst_n,
	input  logic [openfire_pkg::REG_AW-1:0] reg_a_addr,	// From decode
	input  logic [openfire_pkg::REG_AW-1:0] reg_b_addr,
	input  logic [openfire_pkg::REG_AW-1:0] reg_d_addr,
	input  openfire_pkg::rf_sel_e            regfile_input_sel,
	input  logic                             we_alu_branch,
	input  logic                             we_regfile,		// Load writeback
	input  logic                             enable,		// Pipeline advance
	input  logic [openfire_pkg::DATA_W-1:0] result,		// From execute
	input  logic [A_SPACE+1:0]               pc_regfile,		// Byte address
	input  logic [openfire_pkg::DATA_W-1:0] dmem_data,		// From data memory
	output logic [openfire_pkg::DATA_W-1:0] reg_a,
	output logic [openfire_pkg::DATA_W-1:0] reg_b,
	output logic [openfire_pkg::DATA_W-1:0] reg_d			// Store data
);

	localparam int DW = openfire_pkg::DATA_W;
	localparam int BW = openfire_pkg::BYTE_W;
	localparam int HW = openfire_pkg::HALF_W;
	localparam int PW = A_SPACE + 2;	// PC width in bits

	logic          write_en;
	logic [DW-1:0] input_data;		// Selected write data
	logic [DW-1:0] mux_data;		// Mux output before the reset override
	logic [DW-1:0] extended_pc;
	logic [DW-1:0] extended_byte;
	logic [DW-1:0] extended_half;

	// Zero-extended sources
	assign extended_pc   = {{(DW-PW){1'b0}}, pc_regfile};
	assign extended_byte = {{(DW-BW){1'b0}}, dmem_data[DW-1 -: BW]};	// Top lane
	assign extended_half = {{(DW-HW){1'b0}}, dmem_data[DW-1 -: HW]};	// Top two lanes

	// Write on either strobe, only while the pipeline advances
	// r0 is never a target outside reset
	// Reset forces a write so regD gets cleared
	assign write_en = !arst_n ? 1'b1
		: ((we_alu_branch | we_regfile) & (|reg_d_addr) & enable);

	// Write-source select
	always_comb
	begin
		case (regfile_input_sel)
			openfire_pkg::rf_dmem_byte:      mux_data = extended_byte;
			openfire_pkg::rf_dmem_halfword:  mux_data = extended_half;
			openfire_pkg::rf_dmem_wholeword: mux_data = dmem_data;
			openfire_pkg::rf_alu_result:     mux_data = result;
			openfire_pkg::rf_pc:             mux_data = extended_pc;	// Link register
			default:                         mux_data = '0;	// rf_zero, illegal codes
		endcase
	end

	// Zero data during reset
	assign input_data = arst_n ? mux_data : '0;

	// Bank0 serves A and D
	openfire_rf_sram rf_bank0 (
		.clock          (clock),
		.read_addr      (reg_a_addr),
		.write_addr     (reg_d_addr),
		.data_in        (input_data),
		.we             (write_en),
		.read_data_out  (reg_a),
		.write_data_out (reg_d)
	);

	// Bank1 serves B, same write traffic keeps both copies equal
	openfire_rf_sram rf_bank1 (
		.clock          (clock),
		.read_addr      (reg_b_addr),
		.write_addr     (reg_d_addr),
		.data_in        (input_data),
		.we             (write_en),
		.read_data_out  (reg_b),
		.write_data_out ()		// D already read from bank0
	);

endmodule

// File: src/openfire_rf_sram.sv
/*
	One 32-entry register bank
	Synchronous write port, asynchronous reads at the read address
	and at the write address
*/
`timescale 1ns/1ns

module openfire_rf_sram (
	input  logic                             clock,
	input  logic [openfire_pkg::REG_AW-1:0] read_addr,		// Operand port
	input  logic [openfire_pkg::REG_AW-1:0] write_addr,	// Shared with write
	input  logic [openfire_pkg::DATA_W-1:0] data_in,
	input  logic                             we,
	output logic [openfire_pkg::DATA_W-1:0] read_data_out,
	output logic [openfire_pkg::DATA_W-1:0] write_data_out
);

	localparam int DEPTH = 2 ** openfire_pkg::REG_AW;	// One word per register

	// Storage array, maps onto LUT RAM
	logic [openfire_pkg::DATA_W-1:0] mem [0:DEPTH-1];

	// Write on rising edge when enabled
	always_ff @(posedge clock)
	begin
		if (we)
		begin
			mem[write_addr] <= data_in;	// New value visible after the edge
		end
	end

	// Asynchronous reads
	// No bypass, same-cycle read of the write target returns the old word
	assign read_data_out  = mem[read_addr];
	assign write_data_out = mem[write_addr];	// Store data path

endmodule

// File: src/openfire_pkg.sv
/*
	Shared register file definitions
	Datapath and register address widths, load lane widths
	Write-source select codes for the register file input mux
*/
package openfire_pkg;

	// Datapath sizing
	localparam int DATA_W = 32;		// Register and bus width
	localparam int REG_AW = 5;		// 32 architectural registers

	// Load lanes, taken from the top of dmem_data
	localparam int BYTE_W = 8;		// Byte load
	localparam int HALF_W = 16;		// Halfword load

	// Register file write-source select
	// Codes above rf_zero are illegal and write zero
	typedef enum logic [3:0] {
		rf_dmem_byte      = 4'd0,	// Zero-extended byte load
		rf_dmem_halfword  = 4'd1,	// Zero-extended halfword load
		rf_dmem_wholeword = 4'd2,	// Full word load
		rf_alu_result     = 4'd3,	// ALU output
		rf_pc             = 4'd4,	// Program counter, link address
		rf_zero           = 4'd5	// Constant zero
	} rf_sel_e;

endpackage
